/* rtl/sdram_cache_pkg.sv */
// --------------------------------------
// command codes match the 3-bit command
// bus of the SDRAM controller
// address and burst length widths are fixed
// by the controller and not by the caches
// --------------------------------------
`default_nettype none

package sdram_cache_pkg;

  // controller command opcodes
  // other codes of the controller are never issued here
  typedef enum logic [2:0] {
    CmdRefresh  = 3'b001,
    CmdActivate = 3'b011,
    CmdWrite    = 3'b100,
    CmdRead     = 3'b101
  } sdrc_cmd_e;

  // controller address, one 32-bit word per address
  localparam int unsigned SDRC_ADDR_WIDTH = 21;

  // burst length field, holds number of words minus one
  localparam int unsigned SDRC_LEN_WIDTH = 8;

endpackage

`default_nettype wire

/* rtl/bram.sv */
// --------------------------------------
// read-before-write, data_out is the old
// word in the cycle after a write
// contents start at zero (FPGA init)
// --------------------------------------
`default_nettype none

module bram #(
  parameter int unsigned AddressBitWidth = 4
) (
  input wire clk,
  input wire [3:0] write_enable,
  input wire [AddressBitWidth-1:0] address,
  input wire [31:0] data_in,
  output logic [31:0] data_out
);

  localparam int unsigned DEPTH = 2 ** AddressBitWidth;

  logic [31:0] mem[DEPTH];

  // zero contents so tag valid flags start cleared
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    // one enable per byte lane
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][b*8+:8] <= data_in[b*8+:8];
      end
    end
    // read on every edge
    data_out <= mem[address];
  end

endmodule

`default_nettype wire

/* rtl/cache.sv */
// --------------------------------------
// client holds address, data and mask
// while busy and one cycle after
// needs 1 <= tag bits <= 30 and read
// latency below 64 cycles
// --------------------------------------
`default_nettype none

module cache #(
  parameter int unsigned ColumnIndexBitwidth = 3,
  parameter int unsigned LineIndexBitWidth = 4,
  parameter int unsigned RamAddressBitWidth = 10,
  parameter int unsigned WaitsPriorToDataAtRead = 4
) (
  input wire clk,
  input wire rst_n,

  // client port
  input wire enable,
  input wire [31:0] address,
  input wire [31:0] data_in,
  input wire [3:0] write_enable,
  output logic [31:0] data_out,
  output logic data_out_ready,
  output logic busy,

  // bus ownership
  output logic burst_req,
  input wire burst_gnt,

  // controller command interface
  output logic sdrc_cmd_en,
  output sdram_cache_pkg::sdrc_cmd_e sdrc_cmd,
  output logic [sdram_cache_pkg::SDRC_ADDR_WIDTH-1:0] sdrc_addr,
  output logic [31:0] sdrc_data,
  output logic [sdram_cache_pkg::SDRC_LEN_WIDTH-1:0] sdrc_data_len,
  input wire [31:0] sdrc_rdata,
  input wire sdrc_cmd_ack
);

  import sdram_cache_pkg::*;

  localparam int unsigned COLUMN_COUNT = 2 ** ColumnIndexBitwidth;
  localparam int unsigned TAG_W = RamAddressBitWidth - LineIndexBitWidth - ColumnIndexBitwidth;

  typedef enum logic [3:0] {
    Idle,
    Request,
    EvictActivate,
    EvictWrite,
    EvictAck,
    FillActivate,
    FillRead,
    FillData,
    FillTag,
    Release
  } state_e;

  state_e state;

  // burst word counter, also waits out the read latency
  logic [5:0] counter;

  // word address split as |tag|line|col|
  wire [RamAddressBitWidth-1:0] word_addr = address[RamAddressBitWidth+1:2];
  wire [ColumnIndexBitwidth-1:0] column_ix = word_addr[ColumnIndexBitwidth-1:0];
  wire [LineIndexBitWidth-1:0] line_ix =
    word_addr[LineIndexBitWidth+ColumnIndexBitwidth-1:ColumnIndexBitwidth];
  wire [TAG_W-1:0] address_tag = word_addr[RamAddressBitWidth-1:RamAddressBitWidth-TAG_W];

  // ram outputs belong to the address of the previous edge
  logic [RamAddressBitWidth-1:0] word_addr_q;
  logic ram_stale;

  logic tag_write_enable;
  logic [31:0] tag_data_in;
  logic [31:0] cached_tag_and_flags;
  logic [3:0] column_write_enable[COLUMN_COUNT];
  logic [31:0] column_data_in;
  logic [31:0] column_data_out[COLUMN_COUNT];

  // tag store, {dirty, valid, tag} in the low bits
  bram #(
    .AddressBitWidth(LineIndexBitWidth)
  ) i_tag (
    .clk(clk),
    .write_enable({4{tag_write_enable}}),
    .address(line_ix),
    .data_in(tag_data_in),
    .data_out(cached_tag_and_flags)
  );

  // one ram per column, all read at the same line
  for (genvar i = 0; i < COLUMN_COUNT; i++) begin : g_column
    bram #(
      .AddressBitWidth(LineIndexBitWidth)
    ) i_column (
      .clk(clk),
      .write_enable(column_write_enable[i]),
      .address(line_ix),
      .data_in(column_data_in),
      .data_out(column_data_out[i])
    );
  end

  wire [TAG_W-1:0] cached_tag = cached_tag_and_flags[TAG_W-1:0];
  wire line_valid = cached_tag_and_flags[TAG_W];
  wire line_dirty = cached_tag_and_flags[TAG_W+1];

  // lookup only counts once the rams caught up with the address
  wire settled = (word_addr == word_addr_q) && !ram_stale;
  wire lookup_hit = settled && line_valid && (cached_tag == address_tag);
  wire hit_write = (state == Idle) && enable && lookup_hit && (write_enable != 4'b0000);

  // line base addresses of victim and requested line
  wire [RamAddressBitWidth-1:0] victim_line_address =
    {cached_tag, line_ix, {ColumnIndexBitwidth{1'b0}}};
  wire [RamAddressBitWidth-1:0] fill_line_address =
    {word_addr[RamAddressBitWidth-1:ColumnIndexBitwidth], {ColumnIndexBitwidth{1'b0}}};

  assign data_out = column_data_out[column_ix];
  assign busy = enable && ((state != Idle) || !lookup_hit);
  assign data_out_ready = enable && (state == Idle) && lookup_hit && (write_enable == 4'b0000);

  // ram write select: fill burst, tag update, or client hit write
  always_comb begin
    for (int i = 0; i < COLUMN_COUNT; i++) begin
      column_write_enable[i] = 4'b0000;
    end
    column_data_in = data_in;
    tag_write_enable = 1'b0;
    tag_data_in = '0;
    if (state == FillData) begin
      // incoming burst word goes straight into its column
      column_write_enable[counter[ColumnIndexBitwidth-1:0]] = 4'b1111;
      column_data_in = sdrc_rdata;
    end else if (state == FillTag) begin
      // clean and valid
      tag_write_enable = 1'b1;
      tag_data_in = 32'({2'b01, address_tag});
    end else if (hit_write) begin
      // merge bytes, mark line dirty
      column_write_enable[column_ix] = write_enable;
      tag_write_enable = 1'b1;
      tag_data_in = 32'({2'b11, address_tag});
    end
  end

  always_ff @(posedge clk) begin
    word_addr_q <= word_addr;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= Idle;
      burst_req <= 1'b0;
      sdrc_cmd_en <= 1'b0;
      ram_stale <= 1'b0;
      counter <= '0;
    end else begin
      // any ram write leaves the outputs one cycle behind
      ram_stale <= tag_write_enable || (state == FillData) || hit_write;
      sdrc_cmd_en <= 1'b0;
      unique case (state)
        Idle: begin
          // a new request waits for the old grant to drop
          if (enable && settled && !lookup_hit && !burst_gnt) begin
            burst_req <= 1'b1;
            state <= Request;
          end
        end
        Request: begin
          if (burst_gnt) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= CmdActivate;
            if (line_valid && line_dirty) begin
              sdrc_addr <= SDRC_ADDR_WIDTH'(victim_line_address);
              state <= EvictActivate;
            end else begin
              sdrc_addr <= SDRC_ADDR_WIDTH'(fill_line_address);
              state <= FillActivate;
            end
          end
        end
        EvictActivate: begin
          // word 0 leaves together with the write command
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= CmdWrite;
            sdrc_addr <= SDRC_ADDR_WIDTH'(victim_line_address);
            sdrc_data_len <= SDRC_LEN_WIDTH'(COLUMN_COUNT - 1);
            sdrc_data <= column_data_out[0];
            counter <= 6'd1;
            state <= EvictWrite;
          end
        end
        EvictWrite: begin
          sdrc_data <= column_data_out[counter[ColumnIndexBitwidth-1:0]];
          counter <= counter + 6'd1;
          if (counter == 6'(COLUMN_COUNT - 1)) begin
            state <= EvictAck;
          end
        end
        EvictAck: begin
          // victim is in sdram, open the row of the new line
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= CmdActivate;
            sdrc_addr <= SDRC_ADDR_WIDTH'(fill_line_address);
            state <= FillActivate;
          end
        end
        FillActivate: begin
          if (sdrc_cmd_ack) begin
            sdrc_cmd_en <= 1'b1;
            sdrc_cmd <= CmdRead;
            sdrc_addr <= SDRC_ADDR_WIDTH'(fill_line_address);
            sdrc_data_len <= SDRC_LEN_WIDTH'(COLUMN_COUNT - 1);
            counter <= '0;
            state <= FillRead;
          end
        end
        FillRead: begin
          // counter equals cycles since cmd_en
          if (counter == 6'(WaitsPriorToDataAtRead - 1)) begin
            counter <= '0;
            state <= FillData;
          end else begin
            counter <= counter + 6'd1;
          end
        end
        FillData: begin
          counter <= counter + 6'd1;
          if (counter == 6'(COLUMN_COUNT - 1)) begin
            state <= FillTag;
          end
        end
        FillTag: begin
          // tag written this cycle, give up the bus
          burst_req <= 1'b0;
          state <= Release;
        end
        Release: begin
          if (!burst_gnt) begin
            state <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // commands only go out on an owned bus
  a_cmd_needs_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(sdrc_cmd_en) |-> burst_gnt);

  // ownership is kept until the last ack came back
  a_ack_while_owner: assert property (@(posedge clk) disable iff (!rst_n)
    sdrc_cmd_ack |-> burst_req);

endmodule

`default_nettype wire

/* rtl/sdrc_arbiter.sv */
// --------------------------------------
// refresh waits for the running burst to
// finish, so it may be late by one
// eviction plus fill
// AutoRefreshPeriodCycles below 65534
// --------------------------------------
`default_nettype none

module sdrc_arbiter #(
  parameter int unsigned AutoRefreshPeriodCycles = 200
) (
  input wire clk,
  input wire rst_n,

  input wire burst_req_a,
  input wire burst_req_b,
  output logic burst_gnt_a,
  output logic burst_gnt_b,

  // commands from each cache
  input wire cmd_en_a,
  input wire cmd_en_b,
  input wire sdram_cache_pkg::sdrc_cmd_e cmd_a,
  input wire sdram_cache_pkg::sdrc_cmd_e cmd_b,
  input wire [sdram_cache_pkg::SDRC_ADDR_WIDTH-1:0] addr_a,
  input wire [sdram_cache_pkg::SDRC_ADDR_WIDTH-1:0] addr_b,
  input wire [31:0] data_a,
  input wire [31:0] data_b,
  input wire [sdram_cache_pkg::SDRC_LEN_WIDTH-1:0] len_a,
  input wire [sdram_cache_pkg::SDRC_LEN_WIDTH-1:0] len_b,

  // toward the controller
  output logic sdrc_cmd_en,
  output sdram_cache_pkg::sdrc_cmd_e sdrc_cmd,
  output logic [sdram_cache_pkg::SDRC_ADDR_WIDTH-1:0] sdrc_addr,
  output logic [31:0] sdrc_data,
  output logic [sdram_cache_pkg::SDRC_LEN_WIDTH-1:0] sdrc_data_len,
  input wire sdrc_cmd_ack,

  output logic cmd_ack_a,
  output logic cmd_ack_b
);

  import sdram_cache_pkg::*;

  typedef enum logic [1:0] {
    Idle,
    OwnerA,
    OwnerB,
    Refresh
  } state_e;

  state_e state;
  logic [15:0] refresh_count;
  logic refresh_cmd_en;
  logic last_owner_b;

  wire refresh_due = refresh_count > 16'(AutoRefreshPeriodCycles);

  // owner drives the bus, refresh otherwise
  always_comb begin
    if (burst_gnt_a) begin
      sdrc_cmd_en = cmd_en_a;
      sdrc_cmd = cmd_a;
      sdrc_addr = addr_a;
      sdrc_data = data_a;
      sdrc_data_len = len_a;
    end else if (burst_gnt_b) begin
      sdrc_cmd_en = cmd_en_b;
      sdrc_cmd = cmd_b;
      sdrc_addr = addr_b;
      sdrc_data = data_b;
      sdrc_data_len = len_b;
    end else begin
      sdrc_cmd_en = refresh_cmd_en;
      sdrc_cmd = CmdRefresh;
      sdrc_addr = '0;
      sdrc_data = '0;
      sdrc_data_len = '0;
    end
  end

  // ack only reaches the owner
  assign cmd_ack_a = sdrc_cmd_ack && burst_gnt_a;
  assign cmd_ack_b = sdrc_cmd_ack && burst_gnt_b;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= Idle;
      burst_gnt_a <= 1'b0;
      burst_gnt_b <= 1'b0;
      refresh_cmd_en <= 1'b0;
      last_owner_b <= 1'b1;
      // start past the period, first refresh right after reset
      refresh_count <= 16'(AutoRefreshPeriodCycles + 1);
    end else begin
      refresh_cmd_en <= 1'b0;
      // saturating interval counter
      if (refresh_count != 16'hffff) begin
        refresh_count <= refresh_count + 16'd1;
      end
      unique case (state)
        Idle: begin
          if (refresh_due) begin
            refresh_cmd_en <= 1'b1;
            state <= Refresh;
          end else if (burst_req_a && (!burst_req_b || last_owner_b)) begin
            burst_gnt_a <= 1'b1;
            state <= OwnerA;
          end else if (burst_req_b) begin
            burst_gnt_b <= 1'b1;
            state <= OwnerB;
          end
        end
        OwnerA: begin
          if (!burst_req_a) begin
            burst_gnt_a <= 1'b0;
            last_owner_b <= 1'b0;
            state <= Idle;
          end
        end
        OwnerB: begin
          if (!burst_req_b) begin
            burst_gnt_b <= 1'b0;
            last_owner_b <= 1'b1;
            state <= Idle;
          end
        end
        Refresh: begin
          if (sdrc_cmd_ack) begin
            refresh_count <= '0;
            state <= Idle;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  a_one_owner: assert property (@(posedge clk) disable iff (!rst_n)
    !(burst_gnt_a && burst_gnt_b));

  // grant is held as long as the owner keeps requesting
  a_gnt_held: assert property (@(posedge clk) disable iff (!rst_n)
    (burst_gnt_a && burst_req_a) || (burst_gnt_b && burst_req_b)
    |=> $stable({burst_gnt_a, burst_gnt_b}));

endmodule

`default_nettype wire

/* rtl/cache_subsystem.sv */
// --------------------------------------
// clients a and b are not kept coherent,
// each should use its own half of memory
// --------------------------------------
`default_nettype none

module cache_subsystem #(
  parameter int unsigned ColumnIndexBitwidth = 3,
  parameter int unsigned LineIndexBitWidth = 4,
  parameter int unsigned RamAddressBitWidth = 10,
  parameter int unsigned WaitsPriorToDataAtRead = 4,
  parameter int unsigned AutoRefreshPeriodCycles = 200
) (
  input wire clk,
  input wire rst_n,

  // client port a
  input wire a_enable,
  input wire [31:0] a_address,
  input wire [31:0] a_data_in,
  input wire [3:0] a_write_enable,
  output logic [31:0] a_data_out,
  output logic a_data_out_ready,
  output logic a_busy,

  // client port b
  input wire b_enable,
  input wire [31:0] b_address,
  input wire [31:0] b_data_in,
  input wire [3:0] b_write_enable,
  output logic [31:0] b_data_out,
  output logic b_data_out_ready,
  output logic b_busy,

  // controller command interface
  output logic sdrc_cmd_en,
  output sdram_cache_pkg::sdrc_cmd_e sdrc_cmd,
  output logic [sdram_cache_pkg::SDRC_ADDR_WIDTH-1:0] sdrc_addr,
  output logic [31:0] sdrc_data,
  output logic [sdram_cache_pkg::SDRC_LEN_WIDTH-1:0] sdrc_data_len,
  input wire [31:0] sdrc_rdata,
  input wire sdrc_cmd_ack
);

  import sdram_cache_pkg::*;

  // per cache ownership and command signals
  logic req_a;
  logic req_b;
  logic gnt_a;
  logic gnt_b;
  logic cmd_en_a;
  logic cmd_en_b;
  sdrc_cmd_e cmd_a;
  sdrc_cmd_e cmd_b;
  logic [SDRC_ADDR_WIDTH-1:0] addr_a;
  logic [SDRC_ADDR_WIDTH-1:0] addr_b;
  logic [31:0] data_a;
  logic [31:0] data_b;
  logic [SDRC_LEN_WIDTH-1:0] len_a;
  logic [SDRC_LEN_WIDTH-1:0] len_b;
  logic ack_a;
  logic ack_b;

  cache #(
    .ColumnIndexBitwidth(ColumnIndexBitwidth),
    .LineIndexBitWidth(LineIndexBitWidth),
    .RamAddressBitWidth(RamAddressBitWidth),
    .WaitsPriorToDataAtRead(WaitsPriorToDataAtRead)
  ) i_cache_a (
    .clk(clk),
    .rst_n(rst_n),
    .enable(a_enable),
    .address(a_address),
    .data_in(a_data_in),
    .write_enable(a_write_enable),
    .data_out(a_data_out),
    .data_out_ready(a_data_out_ready),
    .busy(a_busy),
    .burst_req(req_a),
    .burst_gnt(gnt_a),
    .sdrc_cmd_en(cmd_en_a),
    .sdrc_cmd(cmd_a),
    .sdrc_addr(addr_a),
    .sdrc_data(data_a),
    .sdrc_data_len(len_a),
    .sdrc_rdata(sdrc_rdata),
    .sdrc_cmd_ack(ack_a)
  );

  cache #(
    .ColumnIndexBitwidth(ColumnIndexBitwidth),
    .LineIndexBitWidth(LineIndexBitWidth),
    .RamAddressBitWidth(RamAddressBitWidth),
    .WaitsPriorToDataAtRead(WaitsPriorToDataAtRead)
  ) i_cache_b (
    .clk(clk),
    .rst_n(rst_n),
    .enable(b_enable),
    .address(b_address),
    .data_in(b_data_in),
    .write_enable(b_write_enable),
    .data_out(b_data_out),
    .data_out_ready(b_data_out_ready),
    .busy(b_busy),
    .burst_req(req_b),
    .burst_gnt(gnt_b),
    .sdrc_cmd_en(cmd_en_b),
    .sdrc_cmd(cmd_b),
    .sdrc_addr(addr_b),
    .sdrc_data(data_b),
    .sdrc_data_len(len_b),
    .sdrc_rdata(sdrc_rdata),
    .sdrc_cmd_ack(ack_b)
  );

  // bus owner and refresh scheduler
  sdrc_arbiter #(
    .AutoRefreshPeriodCycles(AutoRefreshPeriodCycles)
  ) i_arbiter (
    .clk(clk),
    .rst_n(rst_n),
    .burst_req_a(req_a),
    .burst_req_b(req_b),
    .burst_gnt_a(gnt_a),
    .burst_gnt_b(gnt_b),
    .cmd_en_a(cmd_en_a),
    .cmd_en_b(cmd_en_b),
    .cmd_a(cmd_a),
    .cmd_b(cmd_b),
    .addr_a(addr_a),
    .addr_b(addr_b),
    .data_a(data_a),
    .data_b(data_b),
    .len_a(len_a),
    .len_b(len_b),
    .sdrc_cmd_en(sdrc_cmd_en),
    .sdrc_cmd(sdrc_cmd),
    .sdrc_addr(sdrc_addr),
    .sdrc_data(sdrc_data),
    .sdrc_data_len(sdrc_data_len),
    .sdrc_cmd_ack(sdrc_cmd_ack),
    .cmd_ack_a(ack_a),
    .cmd_ack_b(ack_b)
  );

endmodule

`default_nettype wire

/* testbench/sdrc_model.sv */
// --------------------------------------
// behavioural controller, one command at a time
// read data at fixed latency, acks delayed by an LFSR
// no ack for read, done after the last word
// --------------------------------------
`default_nettype none

module sdrc_model #(
  parameter int unsigned ReadLatency = 4,
  parameter int unsigned AddressBitWidth = 10,
  parameter int unsigned RefreshLimit = 280
) (
  input wire clk,
  input wire rst_n,
  input wire cmd_en,
  input wire sdram_cache_pkg::sdrc_cmd_e cmd,
  input wire [sdram_cache_pkg::SDRC_ADDR_WIDTH-1:0] addr,
  input wire [31:0] data,
  input wire [sdram_cache_pkg::SDRC_LEN_WIDTH-1:0] data_len,
  output logic [31:0] rdata,
  output logic cmd_ack,
  output logic protocol_error,
  output int unsigned refresh_total
);
  timeunit 1ns;
  timeprecision 1ps;

  import sdram_cache_pkg::*;

  localparam int unsigned DEPTH = 2 ** AddressBitWidth;

  logic [31:0] mem[DEPTH];
  logic busy_cmd;
  sdrc_cmd_e cur_cmd;
  logic [AddressBitWidth-1:0] cur_addr;
  int unsigned cur_len;
  int unsigned phase;
  int unsigned ack_at;
  int signed word_ix;
  logic [15:0] lfsr;
  longint unsigned cycle;
  longint unsigned last_refresh;

  // preload word mixes every address bit
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = (32'(i) * 32'h9e3779b1) ^ {16'(i), 16'hc3a5};
    end
    protocol_error = 1'b0;
    refresh_total = 0;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      busy_cmd = 1'b0;
      cycle = 0;
      last_refresh = 0;
      lfsr = 16'hace1;
      cmd_ack <= 1'b0;
      rdata <= '0;
    end else begin
      cycle = cycle + 1;
      cmd_ack <= 1'b0;
      lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
      // a visible ack ends its command
      if (cmd_ack) begin
        busy_cmd = 1'b0;
      end
      if (busy_cmd) begin
        phase = phase + 1;
        if (cur_cmd == CmdWrite && phase <= cur_len) begin
          mem[cur_addr + AddressBitWidth'(phase)] = data;
        end
        if (cur_cmd != CmdRead && phase == ack_at) begin
          cmd_ack <= 1'b1;
        end
      end
      if (cmd_en) begin
        if (busy_cmd) begin
          $display("controller model: cmd_en while a command is outstanding at %0t", $time);
          protocol_error <= 1'b1;
        end
        busy_cmd = 1'b1;
        cur_cmd = cmd;
        cur_addr = addr[AddressBitWidth-1:0];
        cur_len = 32'(data_len);
        phase = 0;
        ack_at = 1 + 32'(lfsr[1:0]);
        if (cmd == CmdWrite) begin
          // word 0 arrives with the command
          mem[cur_addr] = data;
          ack_at = cur_len + 1 + 32'(lfsr[1:0]);
        end
        if (cmd == CmdRefresh) begin
          last_refresh = cycle;
          refresh_total = refresh_total + 1;
        end
      end
      // word k must be on rdata in cycle ReadLatency + k
      if (busy_cmd && cur_cmd == CmdRead) begin
        word_ix = int'(phase) + 1 - int'(ReadLatency);
        if (word_ix >= 0 && word_ix <= int'(cur_len)) begin
          rdata <= mem[cur_addr + AddressBitWidth'(word_ix)];
        end
        if (word_ix == int'(cur_len) + 1) begin
          busy_cmd = 1'b0;
        end
      end
      if (cycle - last_refresh > 64'(RefreshLimit)) begin
        $display("controller model: refresh overdue at %0t", $time);
        protocol_error <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_cache_subsystem.sv */
// --------------------------------------
// random traffic on both ports, port a in the
// lower half of memory and port b in the upper
// stops at the first mismatch
// --------------------------------------
`default_nettype none

module tb_cache_subsystem;
  timeunit 1ns;
  timeprecision 1ps;

  import sdram_cache_pkg::*;

  localparam int unsigned COL_W = 3;
  localparam int unsigned LINE_W = 4;
  localparam int unsigned RAM_W = 10;
  localparam int unsigned READ_WAIT = 4;
  localparam int unsigned REFRESH_PERIOD = 200;
  // longest eviction plus fill with the slowest acks
  localparam int unsigned MAX_TXN_CYCLES = 80;
  localparam int unsigned OPS = 300;
  localparam int unsigned CYCLE_LIMIT = (OPS + 10) * 40 + 200;

  logic clk;
  logic rst_n;
  logic a_enable;
  logic [31:0] a_address;
  logic [31:0] a_data_in;
  logic [3:0] a_write_enable;
  logic [31:0] a_data_out;
  logic a_data_out_ready;
  logic a_busy;
  logic b_enable;
  logic [31:0] b_address;
  logic [31:0] b_data_in;
  logic [3:0] b_write_enable;
  logic [31:0] b_data_out;
  logic b_data_out_ready;
  logic b_busy;
  logic sdrc_cmd_en;
  sdrc_cmd_e sdrc_cmd;
  logic [SDRC_ADDR_WIDTH-1:0] sdrc_addr;
  logic [31:0] sdrc_data;
  logic [SDRC_LEN_WIDTH-1:0] sdrc_data_len;
  logic [31:0] sdrc_rdata;
  logic sdrc_cmd_ack;
  logic protocol_error;
  int unsigned refresh_total;

  // reference memory, one byte per lane
  logic [7:0] ref_bytes[2**RAM_W][4];
  int unsigned cycles;

  cache_subsystem #(
    .ColumnIndexBitwidth(COL_W),
    .LineIndexBitWidth(LINE_W),
    .RamAddressBitWidth(RAM_W),
    .WaitsPriorToDataAtRead(READ_WAIT),
    .AutoRefreshPeriodCycles(REFRESH_PERIOD)
  ) i_dut (
    .clk(clk), .rst_n(rst_n),
    .a_enable(a_enable), .a_address(a_address), .a_data_in(a_data_in),
    .a_write_enable(a_write_enable), .a_data_out(a_data_out),
    .a_data_out_ready(a_data_out_ready), .a_busy(a_busy),
    .b_enable(b_enable), .b_address(b_address), .b_data_in(b_data_in),
    .b_write_enable(b_write_enable), .b_data_out(b_data_out),
    .b_data_out_ready(b_data_out_ready), .b_busy(b_busy),
    .sdrc_cmd_en(sdrc_cmd_en), .sdrc_cmd(sdrc_cmd), .sdrc_addr(sdrc_addr),
    .sdrc_data(sdrc_data), .sdrc_data_len(sdrc_data_len),
    .sdrc_rdata(sdrc_rdata), .sdrc_cmd_ack(sdrc_cmd_ack)
  );

  sdrc_model #(
    .ReadLatency(READ_WAIT),
    .AddressBitWidth(RAM_W),
    .RefreshLimit(REFRESH_PERIOD + MAX_TXN_CYCLES)
  ) i_model (
    .clk(clk), .rst_n(rst_n), .cmd_en(sdrc_cmd_en), .cmd(sdrc_cmd),
    .addr(sdrc_addr), .data(sdrc_data), .data_len(sdrc_data_len),
    .rdata(sdrc_rdata), .cmd_ack(sdrc_cmd_ack),
    .protocol_error(protocol_error), .refresh_total(refresh_total)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] ref_word(input logic [RAM_W-1:0] word);
    return {ref_bytes[word][3], ref_bytes[word][2], ref_bytes[word][1], ref_bytes[word][0]};
  endfunction

  task automatic drive_port(input bit port, input bit en, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] mask);
    if (port) begin
      b_enable = en;
      b_address = addr;
      b_data_in = wdata;
      b_write_enable = mask;
    end else begin
      a_enable = en;
      a_address = addr;
      a_data_in = wdata;
      a_write_enable = mask;
    end
  endtask

  // one client access, mask zero means read
  task automatic do_op(input bit port, input logic [RAM_W-1:0] word,
                       input logic [31:0] wdata, input logic [3:0] mask);
    bit done;
    @(negedge clk);
    drive_port(port, 1'b1, {20'd0, word, 2'b00}, wdata, mask);
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (mask == 4'b0000) begin
        done = port ? b_data_out_ready : a_data_out_ready;
      end else begin
        done = !(port ? b_busy : a_busy);
      end
    end
    if (mask == 4'b0000) begin
      check_value(port ? "b_data_out" : "a_data_out", port ? b_data_out : a_data_out,
                  ref_word(word));
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (mask[b]) begin
          ref_bytes[word][b] = wdata[b*8+:8];
        end
      end
    end
    // completion edge, then one held cycle
    @(posedge clk);
    @(posedge clk);
    @(negedge clk);
    drive_port(port, 1'b0, '0, '0, 4'b0000);
  endtask

  // few tags per port so the same lines keep colliding
  task automatic port_traffic(input bit port);
    logic [2:0] tag;
    logic [RAM_W-1:0] word;
    logic [3:0] mask;
    for (int n = 0; n < OPS; n++) begin
      tag = {port, 1'b0, ($urandom % 8 == 0)};
      word = {tag, 4'($urandom % 16), 3'($urandom % 8)};
      mask = ($urandom % 2 == 0) ? 4'b0000 : 4'($urandom % 16);
      do_op(port, word, $urandom, mask);
    end
  endtask

  always @(posedge clk) begin
    cycles++;
    if (protocol_error) begin
      $display("sim failed");
      $fatal(1);
    end else if (cycles > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $fatal(1);
    end
  end

  initial begin
    void'($urandom(32'h70ffa8b3));
    cycles = 0;
    rst_n = 1'b0;
    drive_port(1'b0, 1'b0, '0, '0, 4'b0000);
    drive_port(1'b1, 1'b0, '0, '0, 4'b0000);
    for (int i = 0; i < 2**RAM_W; i++) begin
      for (int b = 0; b < 4; b++) begin
        ref_bytes[i][b] = 8'(((32'(i) * 32'h9e3779b1) ^ {16'(i), 16'hc3a5}) >> (b * 8));
      end
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("a_busy", 32'(a_busy), 0);
    check_value("b_busy", 32'(b_busy), 0);
    check_value("a_data_out_ready", 32'(a_data_out_ready), 0);
    check_value("b_data_out_ready", 32'(b_data_out_ready), 0);
    // controller idles once the first refresh is acked
    while (refresh_total == 0) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    check_value("sdrc_cmd_en", 32'(sdrc_cmd_en), 0);
    // preload read, byte merge, dirty eviction, reread
    do_op(1'b0, {3'd0, 4'd3, 3'd2}, 32'h0, 4'b0000);
    do_op(1'b0, {3'd0, 4'd3, 3'd2}, 32'h11223344, 4'b0101);
    do_op(1'b0, {3'd0, 4'd3, 3'd2}, 32'h0, 4'b0000);
    do_op(1'b0, {3'd1, 4'd3, 3'd2}, 32'hdeadbeef, 4'b1111);
    do_op(1'b0, {3'd0, 4'd3, 3'd2}, 32'h0, 4'b0000);
    // misses on both ports at once
    fork
      do_op(1'b0, {3'd2, 4'd7, 3'd5}, 32'h0, 4'b0000);
      do_op(1'b1, {3'd6, 4'd7, 3'd5}, 32'h0, 4'b0000);
    join
    fork
      port_traffic(1'b0);
      port_traffic(1'b1);
    join
    repeat (4) @(negedge clk);
    if (protocol_error == 1'b0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
rtl/sdram_cache_pkg.sv
rtl/bram.sv
rtl/cache.sv
rtl/sdrc_arbiter.sv
rtl/cache_subsystem.sv
testbench/sdrc_model.sv
testbench/tb_cache_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_cache_subsystem \
  -Mdir obj_dir \
  && ./obj_dir/Vtb_cache_subsystem | grep -x "sim passed" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
